//--- common/stackPkg.sv
`default_nettype none

package stackPkg;

    // ****************************************
    // storage geometry
    // ****************************************

    // five entries, addressed modulo five.
    localparam int stackDepth = 5;

    localparam int dataWidth = 4;

    // pointer and addresses hold 0..4 only.
    localparam int ptrWidth = 3;

    // index 5..7 folds back to 0..2.
    localparam int indexWidth = 3;

    // highest legal pointer value, where increment wraps.
    localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(stackDepth - 1);

    // ****************************************
    // command encodings
    // ****************************************

    localparam int commandWidth = 2;

    localparam logic [commandWidth-1:0] cmdNop  = 2'd0;  // idle.
    localparam logic [commandWidth-1:0] cmdPush = 2'd1;  // write then increment.
    localparam logic [commandWidth-1:0] cmdPop  = 2'd2;  // decrement then read.
    localparam logic [commandWidth-1:0] cmdGet  = 2'd3;  // read below top, pointer kept.

endpackage : stackPkg

`default_nettype wire

//--- common/stackMemIf.sv
`timescale 1ns/10ps
`default_nettype none

// request side is combinational, completes at the next CLK edge.
interface stackMemIf;

    logic                           writeEnable;
    logic [stackPkg::ptrWidth-1:0]  writeAddr;
    logic [stackPkg::dataWidth-1:0] writeData;

    logic                           readEnable;
    logic [stackPkg::ptrWidth-1:0]  readAddr;
    logic [stackPkg::dataWidth-1:0] readData;  // registered in storage.

    modport control (
        output writeEnable,
        output writeAddr,
        output writeData,
        output readEnable,
        output readAddr,
        input  readData
    );

    modport storage (
        input  writeEnable,
        input  writeAddr,
        input  writeData,
        input  readEnable,
        input  readAddr,
        output readData
    );

endinterface : stackMemIf

`default_nettype wire

//--- hw/stackControl.sv
`timescale 1ns/10ps
`default_nettype none

module stackControl (
    input  logic                              CLK,
    input  logic                              reset,
    input  logic [stackPkg::commandWidth-1:0] command,
    input  logic [stackPkg::indexWidth-1:0]   index,
    input  logic [stackPkg::dataWidth-1:0]    dataIn,
    stackMemIf.control                        mem
);

    // ****************************************
    // modulo-five helpers
    // ****************************************

    function automatic logic [stackPkg::ptrWidth-1:0] modIncrement(
        input logic [stackPkg::ptrWidth-1:0] value
    );
        logic [stackPkg::ptrWidth-1:0] result;
        if (value == stackPkg::lastPtr) begin
            result = '0;
        end else begin
            result = value + 1'b1;
        end
        return result;
    endfunction

    function automatic logic [stackPkg::ptrWidth-1:0] modDecrement(
        input logic [stackPkg::ptrWidth-1:0] value
    );
        logic [stackPkg::ptrWidth-1:0] result;
        if (value == '0) begin
            result = stackPkg::lastPtr;  // wraps below entry zero.
        end else begin
            result = value - 1'b1;
        end
        return result;
    endfunction

    // index values past the last entry fold back once.
    function automatic logic [stackPkg::ptrWidth-1:0] foldIndex(
        input logic [stackPkg::indexWidth-1:0] value
    );
        logic [stackPkg::indexWidth-1:0] folded;
        folded = value;
        if (value >= (stackPkg::indexWidth)'(stackPkg::stackDepth)) begin
            folded = value - (stackPkg::indexWidth)'(stackPkg::stackDepth);
        end
        return (stackPkg::ptrWidth)'(folded);
    endfunction

    // a - b modulo five, both operands already in 0..4.
    function automatic logic [stackPkg::ptrWidth-1:0] modSubtract(
        input logic [stackPkg::ptrWidth-1:0] a,
        input logic [stackPkg::ptrWidth-1:0] b
    );
        logic [stackPkg::ptrWidth:0] wide;
        wide = {1'b0, a} + (stackPkg::ptrWidth + 1)'(stackPkg::stackDepth) - {1'b0, b};
        if (wide >= (stackPkg::ptrWidth + 1)'(stackPkg::stackDepth)) begin
            wide = wide - (stackPkg::ptrWidth + 1)'(stackPkg::stackDepth);
        end
        return wide[stackPkg::ptrWidth-1:0];
    endfunction

    // ****************************************
    // command decode
    // ****************************************

    logic isPush;
    logic isPop;
    logic isGet;

    assign isPush = (command == stackPkg::cmdPush);
    assign isPop  = (command == stackPkg::cmdPop);
    assign isGet  = (command == stackPkg::cmdGet);

    // ****************************************
    // top pointer
    // ****************************************

    logic [stackPkg::ptrWidth-1:0] topPtr;
    logic [stackPkg::ptrWidth-1:0] belowTop;  // entry last pushed.
    logic [stackPkg::ptrWidth-1:0] getAddr;

    assign belowTop = modDecrement(topPtr);
    assign getAddr  = modSubtract(belowTop, foldIndex(index));

    always_ff @(posedge CLK) begin
        if (reset) begin
            topPtr <= '0;
        end else if (isPush) begin
            topPtr <= modIncrement(topPtr);
        end else if (isPop) begin
            topPtr <= belowTop;
        end
        // nop and get keep the pointer.
    end

    // ****************************************
    // storage requests
    // ****************************************

    always_comb begin
        mem.writeEnable = isPush;
        mem.writeAddr   = topPtr;  // push lands at the current top.
        mem.writeData   = dataIn;
        mem.readEnable  = isPop | isGet;
        mem.readAddr    = isGet ? getAddr : belowTop;
    end

endmodule : stackControl

`default_nettype wire

//--- hw/stackStorage.sv
`timescale 1ns/10ps
`default_nettype none

module stackStorage (
    input  logic                           CLK,
    input  logic                           reset,
    stackMemIf.storage                     mem,
    output logic [stackPkg::dataWidth-1:0] dataOut,
    output logic                           dataValid
);

    // ****************************************
    // register file
    // ****************************************

    logic [stackPkg::dataWidth-1:0] entries [stackPkg::stackDepth];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < stackPkg::stackDepth; i++) begin
                entries[i] <= '0;
            end
        end else if (mem.writeEnable) begin
            entries[mem.writeAddr] <= mem.writeData;
        end
    end

    // ****************************************
    // registered read port
    // ****************************************

    // read samples the array before any write at the same edge.
    always_ff @(posedge CLK) begin
        if (reset) begin
            mem.readData <= '0;
            dataValid    <= 1'b0;
        end else begin
            dataValid <= mem.readEnable;  // high for one cycle only.
            if (mem.readEnable) begin
                mem.readData <= entries[mem.readAddr];
            end
        end
    end

    // holds the last read value between reads.
    assign dataOut = mem.readData;

endmodule : stackStorage

`default_nettype wire

//--- hw/stackTop.sv
`timescale 1ns/10ps
`default_nettype none

module stackTop (
    input  logic                              CLK,
    input  logic                              reset,
    input  logic [stackPkg::commandWidth-1:0] command,
    input  logic [stackPkg::indexWidth-1:0]   index,
    input  logic [stackPkg::dataWidth-1:0]    dataIn,
    output logic [stackPkg::dataWidth-1:0]    dataOut,
    output logic                              dataValid
);

    // ****************************************
    // control to storage link
    // ****************************************

    stackMemIf memBus ();

    // ****************************************
    // pointer and address generation
    // ****************************************

    stackControl controlUnit (
        .CLK     (CLK),
        .reset   (reset),
        .command (command),
        .index   (index),
        .dataIn  (dataIn),
        .mem     (memBus.control)
    );

    // ****************************************
    // five-entry register file
    // ****************************************

    // read data shows up one cycle after a pop or get.
    stackStorage storageUnit (
        .CLK       (CLK),
        .reset     (reset),
        .mem       (memBus.storage),
        .dataOut   (dataOut),
        .dataValid (dataValid)
    );

endmodule : stackTop

`default_nettype wire

//--- verif/stackClockGen.sv
`timescale 1ns/10ps
`default_nettype none

module stackClockGen (
    output logic CLK,
    output logic reset
);

    localparam int halfPeriod   = 20;  // 40 ns period.
    localparam int resetCycles  = 16;
    localparam int releaseDelay = 2;

    initial begin
        CLK = 1'b0;
        forever #halfPeriod CLK = ~CLK;
    end

    // released just after an edge, like the other inputs.
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge CLK);
        #releaseDelay;
        reset = 1'b0;
    end

endmodule : stackClockGen

`default_nettype wire

//--- verif/stackChecker.sv
`timescale 1ns/10ps
`default_nettype none

module stackChecker (
    input  logic                              CLK,
    input  logic                              reset,
    input  logic [stackPkg::commandWidth-1:0] command,
    input  logic [stackPkg::indexWidth-1:0]   index,
    input  logic [stackPkg::dataWidth-1:0]    dataIn,
    input  logic [stackPkg::dataWidth-1:0]    dataOut,
    input  logic                              dataValid,
    output logic [31:0]                       errorCount,
    output logic [31:0]                       checkCount
);

    localparam int memBits = stackPkg::stackDepth * stackPkg::dataWidth;

    logic [memBits-1:0]             modelMem;  // entry i at bits i*4.
    int                             modelPtr;
    logic [stackPkg::dataWidth-1:0] expData;
    logic                           expValid;

    // value a pop or get returns, given the pointer before the command.
    function automatic logic [stackPkg::dataWidth-1:0] referenceRead(
        input logic [memBits-1:0]                mem,
        input int                                ptr,
        input logic [stackPkg::commandWidth-1:0] cmd,
        input logic [stackPkg::indexWidth-1:0]   idx
    );
        int depth;
        int folded;
        int addr;
        depth  = stackPkg::stackDepth;
        folded = int'(idx) % depth;
        if (cmd == stackPkg::cmdPop) begin
            addr = (ptr + depth - 1) % depth;
        end else begin
            addr = (ptr + 2 * depth - 1 - folded) % depth;
        end
        return mem[addr * stackPkg::dataWidth +: stackPkg::dataWidth];
    endfunction

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    // ****************************************
    // reference model, stepped at each edge
    // ****************************************

    always @(posedge CLK) begin
        if (reset) begin
            modelMem = '0;
            modelPtr = 0;
            expData  = '0;
            expValid = 1'b0;
        end else begin
            expValid = 1'b0;  // dataOut keeps its value otherwise.
            case (command)
                stackPkg::cmdPush: begin
                    modelMem[modelPtr * stackPkg::dataWidth +: stackPkg::dataWidth] = dataIn;
                    modelPtr = (modelPtr + 1) % stackPkg::stackDepth;
                end
                stackPkg::cmdPop: begin
                    expData  = referenceRead(modelMem, modelPtr, command, index);
                    expValid = 1'b1;
                    modelPtr = (modelPtr + stackPkg::stackDepth - 1) % stackPkg::stackDepth;
                end
                stackPkg::cmdGet: begin
                    expData  = referenceRead(modelMem, modelPtr, command, index);
                    expValid = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // ****************************************
    // compare mid-cycle, outputs settled
    // ****************************************

    always @(negedge CLK) begin
        if (!reset) begin
            checkCount = checkCount + 1;
            if (dataValid !== expValid) begin
                errorCount = errorCount + 1;
                $display("Error at %0t: dataValid expected %b, got %b",
                         $time, expValid, dataValid);
            end
            if (dataOut !== expData) begin
                errorCount = errorCount + 1;
                $display("Error at %0t: dataOut expected %h, got %h",
                         $time, expData, dataOut);
            end
        end
    end

endmodule : stackChecker

`default_nettype wire

//--- verif/stackTb.sv
`timescale 1ns/10ps
`default_nettype none

module stackTb;

    localparam int resetCycles    = 16;
    localparam int directedCycles = 50;
    localparam int randomCycles   = 200;
    localparam int marginCycles   = 134;
    localparam int timeoutCycles  = resetCycles + directedCycles + randomCycles + marginCycles;
    localparam int driveDelay     = 2;

    logic                              CLK;
    logic                              reset;
    logic [stackPkg::commandWidth-1:0] command;
    logic [stackPkg::indexWidth-1:0]   index;
    logic [stackPkg::dataWidth-1:0]    dataIn;
    logic [stackPkg::dataWidth-1:0]    dataOut;
    logic                              dataValid;
    logic [31:0]                       errorCount;
    logic [31:0]                       checkCount;
    logic [7:0]                        lfsrState;
    int                                cycleCount = 0;

    stackClockGen clockGen (.CLK(CLK), .reset(reset));

    stackTop i_dut (
        .CLK       (CLK),
        .reset     (reset),
        .command   (command),
        .index     (index),
        .dataIn    (dataIn),
        .dataOut   (dataOut),
        .dataValid (dataValid)
    );

    stackChecker portChecker (
        .CLK        (CLK),
        .reset      (reset),
        .command    (command),
        .index      (index),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .dataValid  (dataValid),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    // taps 8, 6, 5, 4.
    function automatic logic [7:0] lfsrNext(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic drawBits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[6:0], lfsrState[0]};
        end
    endtask

    task automatic issue(
        input logic [stackPkg::commandWidth-1:0] cmd,
        input logic [stackPkg::indexWidth-1:0]   idx,
        input logic [stackPkg::dataWidth-1:0]    data
    );
        @(posedge CLK);
        #driveDelay;
        command = cmd;
        index   = idx;
        dataIn  = data;
    endtask

    task automatic pushValue(input logic [stackPkg::dataWidth-1:0] data);
        issue(stackPkg::cmdPush, '0, data);
    endtask

    task automatic popValue();
        issue(stackPkg::cmdPop, '0, '0);
    endtask

    task automatic getEntry(input logic [stackPkg::indexWidth-1:0] idx);
        issue(stackPkg::cmdGet, idx, '0);
    endtask

    task automatic idleCycle();
        issue(stackPkg::cmdNop, '0, '0);
    endtask

    initial begin
        logic [7:0] bits;
        logic [stackPkg::commandWidth-1:0] randCmd;
        logic [stackPkg::indexWidth-1:0]   randIdx;
        command   = stackPkg::cmdNop;
        index     = '0;
        dataIn    = '0;
        lfsrState = 8'd74;
        @(negedge reset);

        // ****************************************
        // directed sequences
        // ****************************************

        idleCycle();  // cleared stack reads back zero.
        getEntry(3'd0);
        idleCycle();

        pushValue(4'h3);
        pushValue(4'h7);
        pushValue(4'hA);
        pushValue(4'hC);
        repeat (4) popValue();  // reverse order.

        pushValue(4'h9);
        pushValue(4'h2);
        pushValue(4'h6);
        pushValue(4'hE);
        pushValue(4'h5);
        for (int i = 0; i < 8; i++) begin
            getEntry(i[2:0]);  // 5..7 fold to 0..2.
        end
        popValue();

        for (int i = 0; i < 7; i++) begin
            pushValue(4'h1 + i[3:0]);  // two oldest get overwritten.
        end
        repeat (5) popValue();

        pushValue(4'hB);
        idleCycle();
        idleCycle();
        popValue();
        idleCycle();
        getEntry(3'd1);
        idleCycle();
        idleCycle();

        // ****************************************
        // random commands
        // ****************************************

        for (int n = 0; n < randomCycles; n++) begin
            drawBits(stackPkg::commandWidth, bits);
            randCmd = bits[stackPkg::commandWidth-1:0];
            drawBits(stackPkg::indexWidth, bits);
            randIdx = bits[stackPkg::indexWidth-1:0];
            drawBits(stackPkg::dataWidth, bits);
            issue(randCmd, randIdx, bits[stackPkg::dataWidth-1:0]);
        end

        idleCycle();
        @(posedge CLK);
        @(negedge CLK);
        #1;
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("run timed out after %0d cycles, stimulus did not finish", cycleCount);
            $display("test failed");
            $finish;
        end
    end

endmodule : stackTb

`default_nettype wire

//--- stackTop.f
common/stackPkg.sv
common/stackMemIf.sv
hw/stackControl.sv
hw/stackStorage.sv
hw/stackTop.sv
verif/stackClockGen.sv
verif/stackChecker.sv
verif/stackTb.sv

//--- Bender.yml
package:
  name: stackTop

sources:
  # shared package and interface
  - common/stackPkg.sv
  - common/stackMemIf.sv

  # design
  - hw/stackControl.sv
  - hw/stackStorage.sv
  - hw/stackTop.sv

  # testbench
  - target: simulation
    files:
      - verif/stackClockGen.sv
      - verif/stackChecker.sv
      - verif/stackTb.sv
